/* filelist.f */
design/sigmoidFormatPkg.sv
design/sigmoidCoeffPkg.sv
design/sigmoidCtrl.sv
design/segmentLookup.sv
design/slopeMultiplier.sv
design/outputAssembler.sv
design/sigmoid.sv
testbench/sigmoid_asserts.sv
testbench/tbSigmoid.sv

/* Bender.yml */
package:
  name: sigmoid

sources:
  - design/sigmoidFormatPkg.sv
  - design/sigmoidCoeffPkg.sv
  - design/sigmoidCtrl.sv
  - design/segmentLookup.sv
  - design/slopeMultiplier.sv
  - design/outputAssembler.sv
  - design/sigmoid.sv
  - target: test
    files:
      - testbench/sigmoid_asserts.sv
      - testbench/tbSigmoid.sv

/* testbench/tbSigmoid.sv */
`default_nettype none

module tbSigmoid;

	timeunit 1ns;
	timeprecision 1ps;

	logic                   clk;
	logic                   i_arstN;
	logic                   i_inValid;
	sigmoidFormatPkg::xType i_x;
	sigmoidFormatPkg::yType o_y;
	logic                   o_outValid;

	integer seed;
	int     outCount = 0;
	int     timeoutCount = 0;

	sigmoid DUT (
		.clk        (clk),
		.i_arstN    (i_arstN),
		.i_inValid  (i_inValid),
		.i_x        (i_x),
		.o_y        (o_y),
		.o_outValid (o_outValid)
	);

	bind sigmoid sigmoid_asserts uAsserts (
		.clk        (clk),
		.i_arstN    (i_arstN),
		.i_inValid  (i_inValid),
		.i_x        (i_x),
		.o_y        (o_y),
		.o_outValid (o_outValid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Results seen at the DUT output
	always @(posedge clk) begin
		if (o_outValid) begin
			outCount++;
		end
	end

	task automatic driveSample(input logic valid, input sigmoidFormatPkg::xType x);
		@(negedge clk);
		i_inValid = valid;
		i_x       = x;
	endtask

	task automatic waitForOutputs(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (outCount < target && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (outCount < target) begin
			timeoutCount++;
			$display("Timeout: only %0d of %0d results arrived within %0d cycles",
				outCount, target, limit);
		end
	endtask

	initial begin
		int base;
		int sent;
		logic valid;
		seed      = 32'hfcaf08c1;
		i_arstN   = 1'b0;
		i_inValid = 1'b0;
		i_x       = '0;

		repeat (5) @(negedge clk);
		i_arstN = 1'b1;

		// Full sweep back to back, covers -128 and every x, -x pair
		base = outCount;
		for (int v = 0; v < 256; v++) begin
			driveSample(1'b1, sigmoidFormatPkg::xType'(v));
		end
		driveSample(1'b0, '0);
		waitForOutputs(base + 256, 20);

		// Random samples with random gaps
		base = outCount;
		sent = 0;
		for (int i = 0; i < 300; i++) begin
			valid = ($random(seed) & 3) != 0;
			if (valid) begin
				sent++;
			end
			driveSample(valid, sigmoidFormatPkg::xType'($random(seed)));
		end
		driveSample(1'b0, '0);
		waitForOutputs(base + sent, 20);

		// Reset while two samples are still inside the pipeline
		driveSample(1'b1, 8'sd37);
		driveSample(1'b1, -8'sd90);
		@(negedge clk);
		i_inValid = 1'b0;
		i_arstN   = 1'b0;
		repeat (3) @(negedge clk);
		i_arstN = 1'b1;

		base = outCount;
		driveSample(1'b1, 8'sd5);
		driveSample(1'b1, -8'sd5);
		driveSample(1'b1, -8'sd128);
		driveSample(1'b0, '0);
		waitForOutputs(base + 3, 20);

		// Let the last assertions sample an idle pipeline
		repeat (4) @(negedge clk);

		$display("Assertion failures: %0d, timeouts: %0d",
			DUT.uAsserts.failCount, timeoutCount);
		if (DUT.uAsserts.failCount == 0 && timeoutCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/sigmoid_asserts.sv */
`default_nettype none

module sigmoid_asserts (
	input wire                         clk,
	input wire                         i_arstN,
	input wire                         i_inValid,
	input wire sigmoidFormatPkg::xType i_x,
	input wire sigmoidFormatPkg::yType o_y,
	input wire                         o_outValid
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FieldLsb = sigmoidFormatPkg::OutLsbPad;
	localparam int FieldMsb = sigmoidFormatPkg::OutLsbPad + sigmoidFormatPkg::OutFieldWidth - 1;
	localparam int WordMsb  = FieldMsb + 1;

	// Read by the testbench at the end of the run
	int failCount = 0;

	// Input delayed to line up with o_y
	sigmoidFormatPkg::xType   xD1;
	sigmoidFormatPkg::xType   xD2;
	sigmoidFormatPkg::xType   xD3;
	sigmoidFormatPkg::magType xIdx;
	sigmoidFormatPkg::magType mirrorIdx;

	// Output field already observed for each input code
	logic [255:0]                  seen = '0;
	sigmoidFormatPkg::outFieldType seenField [256];

	assign xIdx      = sigmoidFormatPkg::magType'(xD3);
	assign mirrorIdx = sigmoidFormatPkg::magType'(-xD3);

	always @(posedge clk) begin
		xD1 <= i_x;
		xD2 <= xD1;
		xD3 <= xD2;
	end

	always @(posedge clk) begin
		if (i_arstN && o_outValid) begin
			seen[xIdx]      <= 1'b1;
			seenField[xIdx] <= o_y[FieldMsb:FieldLsb];
		end
	end

	// Expected field for one sample from the fit rule
	function automatic sigmoidFormatPkg::outFieldType refField(
		input sigmoidFormatPkg::xType x
	);
		int value;
		int mag;
		int sum;
		int field;
		sigmoidCoeffPkg::segType seg;
		value = int'(x);
		mag = (value < 0) ? -value : value;
		if (mag > 127) begin
			seg = sigmoidCoeffPkg::segType'(sigmoidCoeffPkg::SegCount - 1);
		end else begin
			seg = sigmoidCoeffPkg::segType'(mag / 16);
		end
		sum = mag * int'(sigmoidCoeffPkg::SlopeTable[seg]);
		sum = (sum + int'(sigmoidCoeffPkg::InterceptTable[seg])) % 4096;
		field = sum % 2048;
		// Negative half mirrors the positive one
		if (value < 0) begin
			field = 2047 - field;
		end
		return sigmoidFormatPkg::outFieldType'(field);
	endfunction

	function automatic sigmoidFormatPkg::yType refY(input sigmoidFormatPkg::xType x);
		return {1'b0, refField(x), {sigmoidFormatPkg::OutLsbPad{1'b0}}};
	endfunction

	// Outputs held at zero once reset has been low for a full cycle
	resetState: assert property (@(posedge clk)
		(!i_arstN && !$past(i_arstN)) |-> (!o_outValid && o_y == '0))
	else begin
		failCount++;
		$error("Error at %0t: output not cleared during reset", $time);
	end

	// Valid comes out three cycles later unless a reset came in between
	validTiming: assert property (@(posedge clk) disable iff (!i_arstN)
		o_outValid == ($past(i_inValid, 3) && $past(i_arstN, 1)
			&& $past(i_arstN, 2) && $past(i_arstN, 3)))
	else begin
		failCount++;
		$error("Error at %0t: o_outValid is %0b, wrong for the input 3 cycles back",
			$time, o_outValid);
	end

	outputValue: assert property (@(posedge clk) disable iff (!i_arstN)
		o_outValid |-> o_y == refY($past(i_x, 3)))
	else begin
		failCount++;
		$error("Error at %0t: x=%0d gave o_y=%h, expected %h",
			$time, $past(i_x, 3), o_y, refY($past(i_x, 3)));
	end

	// Observed fields of x and -x are complements
	// 0 and -128 are their own mirrors and are skipped
	mirrorField: assert property (@(posedge clk) disable iff (!i_arstN)
		(o_outValid && xD3 != sigmoidFormatPkg::xType'(0)
			&& xD3 != sigmoidFormatPkg::xType'(-128) && seen[mirrorIdx])
		|-> o_y[FieldMsb:FieldLsb] == ~seenField[mirrorIdx])
	else begin
		failCount++;
		$error("Error at %0t: field of x=%0d is not the complement of its mirror",
			$time, $sampled(xD3));
	end

	outputFormat: assert property (@(posedge clk)
		o_y[WordMsb] == 1'b0 && o_y[FieldLsb-1:0] == '0)
	else begin
		failCount++;
		$error("Error at %0t: padding bits of o_y=%h are not zero", $time, o_y);
	end

endmodule

`default_nettype wire

/* design/sigmoid.sv */
`default_nettype none

module sigmoid (
	input  wire                          clk,
	input  wire                          i_arstN,
	input  wire                          i_inValid,
	input  wire sigmoidFormatPkg::xType  i_x,
	output wire sigmoidFormatPkg::yType  o_y,
	output wire                          o_outValid
);

	// Stage 1 outputs
	wire                                 signS1;
	wire sigmoidFormatPkg::magType       magS1;
	wire sigmoidCoeffPkg::slopeType      slopeS1;
	wire sigmoidCoeffPkg::interceptType  interceptS1;

	// Stage 2 outputs
	wire sigmoidFormatPkg::prodType      productS2;
	wire sigmoidCoeffPkg::interceptType  interceptS2;

	// Sign aligned with the stage-3 adder
	wire                                 signS3;

	sigmoidCtrl uCtrl (
		.clk        (clk),
		.i_arstN    (i_arstN),
		.i_inValid  (i_inValid),
		.i_sign     (signS1),
		.o_outValid (o_outValid),
		.o_signS3   (signS3)
	);

	segmentLookup uSegmentLookup (
		.clk         (clk),
		.i_arstN     (i_arstN),
		.i_x         (i_x),
		.o_mag       (magS1),
		.o_slope     (slopeS1),
		.o_intercept (interceptS1),
		.o_sign      (signS1)
	);

	slopeMultiplier uSlopeMultiplier (
		.clk         (clk),
		.i_arstN     (i_arstN),
		.i_mag       (magS1),
		.i_slope     (slopeS1),
		.i_intercept (interceptS1),
		.o_product   (productS2),
		.o_intercept (interceptS2)
	);

	outputAssembler uOutputAssembler (
		.clk         (clk),
		.i_arstN     (i_arstN),
		.i_product   (productS2),
		.i_intercept (interceptS2),
		.i_sign      (signS3),
		.o_y         (o_y)
	);

endmodule

`default_nettype wire

/* design/outputAssembler.sv */
`default_nettype none

module outputAssembler (
	input  wire                                clk,
	input  wire                                i_arstN,
	input  wire sigmoidFormatPkg::prodType     i_product,
	input  wire sigmoidCoeffPkg::interceptType i_intercept,
	input  wire                                i_sign,
	output sigmoidFormatPkg::yType             o_y
);

	sigmoidFormatPkg::prodType      sum;
	sigmoidFormatPkg::outFieldType  field;
	sigmoidFormatPkg::outFieldType  fieldQ;

	// Modulo 4096, carry out is dropped
	assign sum = i_product + i_intercept;

	// Mirrored half, inverting the field gives roughly 1 - y
	assign field = sum[sigmoidFormatPkg::OutFieldWidth-1:0]
		^ {sigmoidFormatPkg::OutFieldWidth{i_sign}};

	// Stage 3 register
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			fieldQ <= '0;
		end else begin
			fieldQ <= field;
		end
	end

	// Field sits at bits 14..4, the rest is constant zero
	assign o_y = {1'b0, fieldQ, {sigmoidFormatPkg::OutLsbPad{1'b0}}};

endmodule

`default_nettype wire

/* design/slopeMultiplier.sv */
`default_nettype none

module slopeMultiplier (
	input  wire                                clk,
	input  wire                                i_arstN,
	input  wire sigmoidFormatPkg::magType      i_mag,
	input  wire sigmoidCoeffPkg::slopeType     i_slope,
	input  wire sigmoidCoeffPkg::interceptType i_intercept,
	output sigmoidFormatPkg::prodType          o_product,
	output sigmoidCoeffPkg::interceptType      o_intercept
);

	sigmoidFormatPkg::prodType product;

	// 8 x 4 bits, largest value 255 * 15 fits in 12 bits
	assign product = i_mag * i_slope;

	// Stage 2 register, intercept rides along to stay aligned
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_product   <= '0;
			o_intercept <= '0;
		end else begin
			o_product   <= product;
			o_intercept <= i_intercept;
		end
	end

endmodule

`default_nettype wire

/* design/segmentLookup.sv */
`default_nettype none

module segmentLookup (
	input  wire                            clk,
	input  wire                            i_arstN,
	input  wire sigmoidFormatPkg::xType    i_x,
	output sigmoidFormatPkg::magType       o_mag,
	output sigmoidCoeffPkg::slopeType      o_slope,
	output sigmoidCoeffPkg::interceptType  o_intercept,
	output logic                           o_sign
);

	logic                      sign;
	sigmoidFormatPkg::magType  absX;
	sigmoidCoeffPkg::segType   seg;

	// Input MSB, also handed to the control path unregistered
	assign sign = i_x[sigmoidFormatPkg::XWidth-1];

	// Fold negative inputs onto the positive half
	// -128 stays 8'h80, read as unsigned 128
	always_comb begin
		if (sign) begin
			absX = sigmoidFormatPkg::magType'(-i_x);
		end else begin
			absX = sigmoidFormatPkg::magType'(i_x);
		end
	end

	// Segments are 16 wide over 0..127
	// Magnitude 128 only comes from -128 and shares the last segment
	always_comb begin
		if (absX[sigmoidFormatPkg::XWidth-1]) begin
			seg = sigmoidCoeffPkg::segType'(sigmoidCoeffPkg::SegCount - 1);
		end else begin
			seg = absX[6:4];
		end
	end

	// Stage 1 register
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_mag       <= '0;
			o_slope     <= '0;
			o_intercept <= '0;
		end else begin
			o_mag       <= absX;
			o_slope     <= sigmoidCoeffPkg::SlopeTable[seg];
			o_intercept <= sigmoidCoeffPkg::InterceptTable[seg];
		end
	end

	assign o_sign = sign;

endmodule

`default_nettype wire

/* design/sigmoidCtrl.sv */
`default_nettype none

module sigmoidCtrl (
	input  wire  clk,
	input  wire  i_arstN,
	input  wire  i_inValid,
	input  wire  i_sign,
	output logic o_outValid,
	output logic o_signS3
);

	// One bit per register stage of the datapath
	localparam int ValidDepth = 3;

	// Sign is consumed ahead of the stage-3 register
	localparam int SignDepth = 2;

	logic [ValidDepth-1:0] validPipe;
	logic [SignDepth-1:0]  signPipe;

	// Valid follows the data through all three stages
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[ValidDepth-2:0], i_inValid};
		end
	end

	// Sign selects the mirrored half at stage 3
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			signPipe <= '0;
		end else begin
			signPipe <= {signPipe[SignDepth-2:0], i_sign};
		end
	end

	assign o_outValid = validPipe[ValidDepth-1];
	assign o_signS3   = signPipe[SignDepth-1];

endmodule

`default_nettype wire

/* design/sigmoidCoeffPkg.sv */
`default_nettype none

package sigmoidCoeffPkg;

	// Eight segments of the piecewise-linear fit
	localparam int SegCount = 8;

	typedef logic [$clog2(SegCount)-1:0] segType;

	// Slope in units of 2^-6
	typedef logic [3:0] slopeType;

	// Intercept in units of 2^-11, same width as the product it is added to
	typedef logic [sigmoidFormatPkg::ProdWidth-1:0] interceptType;

	// Slope per segment, steepest near zero
	localparam slopeType SlopeTable [SegCount] = '{
		4'd15,
		4'd14,
		4'd11,
		4'd8,
		4'd6,
		4'd4,
		4'd2,
		4'd1
	};

	// Intercept per segment
	// Each entry already holds the constant 0.5 (1024) in its top bits
	localparam interceptType InterceptTable [SegCount] = '{
		12'd1027,
		12'd1053,
		12'd1150,
		12'd1295,
		12'd1419,
		12'd1572,
		12'd1762,
		12'd1880
	};

endpackage

`default_nettype wire

/* design/sigmoidFormatPkg.sv */
`default_nettype none

package sigmoidFormatPkg;

	// Input sample, two's complement
	localparam int XWidth = 8;

	typedef logic signed [XWidth-1:0] xType;

	// Folded magnitude, -128 folds to 128 and needs all eight bits
	typedef logic [XWidth-1:0] magType;

	// Width of the product and of product plus intercept
	localparam int ProdWidth = 12;

	// Carries beyond the top bit are dropped
	typedef logic [ProdWidth-1:0] prodType;

	// Significant output field
	localparam int OutFieldWidth = 11;

	typedef logic [OutFieldWidth-1:0] outFieldType;

	// Zero bits below the field
	localparam int OutLsbPad = 4;

	// Output word layout
	// bit 15 is zero, bits 14..4 hold the field, bits 3..0 are zero
	typedef logic [OutFieldWidth+OutLsbPad:0] yType;

endpackage

`default_nettype wire
